/* filelist.f */
design/pspl_pkg.sv
design/axil_decoder.sv
design/spi_master_regs.sv
design/reg_fifo.sv
design/sys_ctrl_regs.sv
design/pl_top.sv
dv/tb_pl_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_pl_top -f filelist.f -o tb_pl_top > build.log 2>&1 \
    && ./obj_dir/tb_pl_top > sim.log 2>&1 \
    || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

tail -n 3 sim.log
grep -q "ERRORS FOUND" sim.log \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

/* dv/tb_pl_top.sv */
// Single AXI-Lite master, one transaction at a time; the SPI slave model works in mode 0 only
module tb_pl_top;
    import pspl_pkg::*;

    localparam int          NUM_TRANSACTIONS = 300;
    localparam int          TIMEOUT_CYCLES   = NUM_TRANSACTIONS * (16 * 255 + 20);
    localparam logic [31:0] OKAY             = 32'(RESP_OKAY);
    localparam logic [31:0] DECERR           = 32'(RESP_DECERR);

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic [31:0] s_axil_awaddr_i, s_axil_wdata_i, s_axil_araddr_i;
    logic [3:0]  s_axil_wstrb_i;
    logic        s_axil_awvalid_i, s_axil_wvalid_i, s_axil_bready_i;
    logic        s_axil_arvalid_i, s_axil_rready_i;
    logic        s_axil_awready_o, s_axil_wready_o, s_axil_arready_o;
    logic        s_axil_bvalid_o, s_axil_rvalid_o;
    logic [1:0]  s_axil_bresp_o, s_axil_rresp_o;
    logic [31:0] s_axil_rdata_o;
    logic        spi_miso_i = 1'b0;
    logic        spi_mosi_o, spi_clk_o;
    logic [0:0]  spi_cs_o;
    logic [7:0]  gpio_o;

    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr = 32'h6c9b;
    logic [31:0] fifo_q[$];
    logic        fifo_ovf = 1'b0;
    logic        fifo_udf = 1'b0;

    logic        prev_cs, prev_sclk;
    logic [7:0]  slave_tx, slave_rx, slave_last_rx;

    pl_top UUT (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test did not finish", cycle_count);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // SPI slave replying with the previous received byte XOR a5
    always @(negedge clk_i) begin
        if (reset_i) begin
            prev_cs       = 1'b1;
            prev_sclk     = 1'b0;
            slave_tx      = 8'h00;
            slave_rx      = 8'h00;
            slave_last_rx = 8'h00;
            spi_miso_i    = 1'b0;
        end else begin
            if (prev_cs && !spi_cs_o[0]) begin
                slave_tx   = slave_last_rx ^ 8'ha5;
                spi_miso_i = slave_tx[7];           // MSB ready before first rising edge
            end else if (!spi_cs_o[0] && !prev_sclk && spi_clk_o) begin
                slave_rx = {slave_rx[6:0], spi_mosi_o};
            end else if (!spi_cs_o[0] && prev_sclk && !spi_clk_o) begin
                slave_tx   = {slave_tx[6:0], 1'b0};
                spi_miso_i = slave_tx[7];
            end else if (!prev_cs && spi_cs_o[0]) begin
                slave_last_rx = slave_rx;
            end
            prev_cs   = spi_cs_o[0];
            prev_sclk = spi_clk_o;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [31:0] base, input logic [1:0] idx);
        return base | (32'(idx) << 2);
    endfunction

    function automatic logic [31:0] fifo_status();
        logic [31:0] s;
        s       = '0;
        s[4:0]  = 5'(fifo_q.size());
        s[8]    = (fifo_q.size() == 0);
        s[9]    = (fifo_q.size() == FIFO_DEPTH);
        s[10]   = fifo_ovf;
        s[11]   = fifo_udf;
        return s;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // No address may be taken while a response is pending
    task automatic check_readies_low();
        compare("awready", 32'(s_axil_awready_o), 32'd0);
        compare("wready", 32'(s_axil_wready_o), 32'd0);
        compare("arready", 32'(s_axil_arready_o), 32'd0);
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [31:0] resp);
        int   lat;
        int   stall;
        logic taken;
        lat   = 0;
        taken = 1'b0;
        @(negedge clk_i);
        s_axil_awaddr_i  = addr;
        s_axil_awvalid_i = 1'b1;
        s_axil_wdata_i   = data;
        s_axil_wstrb_i   = strb;
        s_axil_wvalid_i  = 1'b1;
        while (!taken) begin
            #1;                                     // Ready settled mid low phase
            taken = s_axil_awready_o && s_axil_wready_o;
            @(negedge clk_i);
        end
        s_axil_awvalid_i = 1'b0;
        s_axil_wvalid_i  = 1'b0;
        while (!s_axil_bvalid_o && lat < 8) begin
            @(negedge clk_i);
            lat++;
        end
        compare("bvalid latency", 32'(lat), 32'd2);
        resp  = 32'(s_axil_bresp_o);
        stall = int'(rand_bits(2));
        repeat (stall) begin
            @(negedge clk_i);
            compare("bvalid", 32'(s_axil_bvalid_o), 32'd1);
            compare("bresp", 32'(s_axil_bresp_o), resp);
            check_readies_low();
        end
        s_axil_bready_i = 1'b1;
        @(negedge clk_i);
        s_axil_bready_i = 1'b0;
        compare("bvalid", 32'(s_axil_bvalid_o), 32'd0);
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                             output logic [31:0] resp);
        int   lat;
        int   stall;
        logic taken;
        lat   = 0;
        taken = 1'b0;
        @(negedge clk_i);
        s_axil_araddr_i  = addr;
        s_axil_arvalid_i = 1'b1;
        while (!taken) begin
            #1;
            taken = s_axil_arready_o;
            @(negedge clk_i);
        end
        s_axil_arvalid_i = 1'b0;
        while (!s_axil_rvalid_o && lat < 8) begin
            @(negedge clk_i);
            lat++;
        end
        compare("rvalid latency", 32'(lat), 32'd2);
        resp  = 32'(s_axil_rresp_o);
        data  = s_axil_rdata_o;
        stall = int'(rand_bits(2));
        repeat (stall) begin
            @(negedge clk_i);
            compare("rvalid", 32'(s_axil_rvalid_o), 32'd1);
            compare("rresp", 32'(s_axil_rresp_o), resp);
            compare("rdata", s_axil_rdata_o, data);
            check_readies_low();
        end
        s_axil_rready_i = 1'b1;
        @(negedge clk_i);
        s_axil_rready_i = 1'b0;
        compare("rvalid", 32'(s_axil_rvalid_o), 32'd0);
    endtask

    task automatic write_okay(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic [31:0] resp;
        axil_write(addr, data, strb, resp);
        compare("bresp", resp, OKAY);
    endtask

    task automatic read_check(input string name, input logic [31:0] addr,
                              input logic [31:0] exp);
        logic [31:0] resp;
        logic [31:0] data;
        axil_read(addr, data, resp);
        compare("rresp", resp, OKAY);
        compare(name, data, exp);
    endtask

    initial begin
        logic [31:0] addr, data, resp, exp, scratch_m;
        logic [31:0] wr_resp, rd_resp, rd_data;
        logic [7:0]  gpio_m, tx, spi_last, clkdiv;
        logic [3:0]  strb;
        logic        write_late;
        int          polls;
        s_axil_awaddr_i  = '0;
        s_axil_awvalid_i = 1'b0;
        s_axil_wdata_i   = '0;
        s_axil_wstrb_i   = '0;
        s_axil_wvalid_i  = 1'b0;
        s_axil_bready_i  = 1'b0;
        s_axil_araddr_i  = '0;
        s_axil_arvalid_i = 1'b0;
        s_axil_rready_i  = 1'b0;
        reset_i          = 1'b1;
        repeat (10) @(negedge clk_i);
        reset_i = 1'b0;
        compare("bvalid", 32'(s_axil_bvalid_o), 32'd0);
        compare("rvalid", 32'(s_axil_rvalid_o), 32'd0);
        compare("spi_cs_o", 32'(spi_cs_o), 32'd1);
        compare("spi_clk_o", 32'(spi_clk_o), 32'd0);
        compare("spi_mosi_o", 32'(spi_mosi_o), 32'd0);
        compare("gpio_o", 32'(gpio_o), 32'd0);

        // Unmapped window and random addresses outside every window
        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 1) begin
                addr = {16'h43c3, 16'(rand_bits(16))};
            end else begin
                addr = rand_bits(32);
                if ((addr & WINDOW_MASK) inside {SPI_BASE, FIFO_BASE, SYS_BASE}) begin
                    addr[31] = ~addr[31];
                end
            end
            axil_write(addr, rand_bits(32), 4'hf, resp);
            compare("bresp", resp, DECERR);
            axil_read(addr, data, resp);
            compare("rresp", resp, DECERR);
            compare("rdata", data, 32'd0);
        end

        // Second request held off while the first response is pending
        for (int i = 0; i < 8; i++) begin
            addr       = {16'h43c3, 16'(rand_bits(16))};
            data       = rand_bits(32);
            write_late = (i % 2 == 1);
            fork
                begin
                    if (write_late) @(negedge clk_i);   // Read goes first
                    axil_write(addr, data, 4'hf, wr_resp);
                end
                axil_read(addr, rd_data, rd_resp);
            join
            compare("bresp", wr_resp, DECERR);
            compare("rresp", rd_resp, DECERR);
            compare("rdata", rd_data, 32'd0);
        end
        read_check("id", reg_addr(SYS_BASE, SYS_REG_ID), PL_ID);

        scratch_m = '0;
        for (int i = 0; i < 20; i++) begin
            data = rand_bits(32);
            strb = 4'(rand_bits(4));
            write_okay(reg_addr(SYS_BASE, SYS_REG_SCRATCH), data, strb);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) scratch_m[8*b+:8] = data[8*b+:8];
            end
            read_check("scratch", reg_addr(SYS_BASE, SYS_REG_SCRATCH), scratch_m);
            data   = rand_bits(32);
            gpio_m = data[7:0];
            write_okay(reg_addr(SYS_BASE, SYS_REG_GPIO), data, 4'hf);
            compare("gpio_o", 32'(gpio_o), 32'(gpio_m));
            read_check("gpio", reg_addr(SYS_BASE, SYS_REG_GPIO), 32'(gpio_m));
        end

        // Fill past full, random mix, then drain past empty
        for (int i = 0; i < 72; i++) begin
            if (i < 20 || (i < 44 && rand_bits(1) == 32'd1)) begin
                data = rand_bits(32);
                write_okay(reg_addr(FIFO_BASE, FIFO_REG_DATA), data, 4'hf);
                if (fifo_q.size() == FIFO_DEPTH) fifo_ovf = 1'b1;
                else fifo_q.push_back(data);
            end else begin
                exp = '0;
                if (fifo_q.size() == 0) fifo_udf = 1'b1;
                else exp = fifo_q.pop_front();
                read_check("fifo data", reg_addr(FIFO_BASE, FIFO_REG_DATA), exp);
            end
            read_check("fifo status", reg_addr(FIFO_BASE, FIFO_REG_STATUS), fifo_status());
            if (i == 30 || i == 71) begin
                write_okay(reg_addr(FIFO_BASE, FIFO_REG_CLEAR), 32'd1, 4'hf);
                fifo_ovf = 1'b0;
                fifo_udf = 1'b0;
                read_check("fifo status", reg_addr(FIFO_BASE, FIFO_REG_STATUS), fifo_status());
            end
        end

        read_check("clkdiv", reg_addr(SPI_BASE, SPI_REG_CLKDIV), 32'(SPI_CLKDIV_RESET));
        write_okay(reg_addr(SPI_BASE, SPI_REG_CLKDIV), 32'd0, 4'hf);
        read_check("clkdiv", reg_addr(SPI_BASE, SPI_REG_CLKDIV), 32'd1);   // Zero kept as one
        spi_last = 8'h00;
        for (int i = 0; i < 12; i++) begin
            clkdiv = 8'(rand_bits(3) % 6 + 1);
            write_okay(reg_addr(SPI_BASE, SPI_REG_CLKDIV), 32'(clkdiv), 4'hf);
            tx = 8'(rand_bits(8));
            write_okay(reg_addr(SPI_BASE, SPI_REG_DATA), 32'(tx), 4'hf);
            polls = 0;
            data  = 32'd1;
            while (data[0] && polls < 64) begin
                axil_read(reg_addr(SPI_BASE, SPI_REG_STATUS), data, resp);
                polls++;
            end
            if (data[0]) begin
                errors++;
                $display("SPI transfer %0d still busy after %0d status polls", i, polls);
            end
            read_check("spi rx", reg_addr(SPI_BASE, SPI_REG_DATA), 32'(spi_last ^ 8'ha5));
            compare("slave rx", 32'(slave_last_rx), 32'(tx));
            spi_last = tx;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* design/pl_top.sv */
// Fabric side only; the external AXI-Lite master and all peripherals share clk_i
module pl_top (
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  logic [pspl_pkg::AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr_i,
    input  logic                                   s_axil_awvalid_i,
    output logic                                   s_axil_awready_o,
    input  logic [pspl_pkg::AXIL_DATA_WIDTH-1:0]   s_axil_wdata_i,
    input  logic [pspl_pkg::AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb_i,
    input  logic                                   s_axil_wvalid_i,
    output logic                                   s_axil_wready_o,
    output logic                                   s_axil_bvalid_o,
    output logic [1:0]                             s_axil_bresp_o,
    input  logic                                   s_axil_bready_i,
    input  logic [pspl_pkg::AXIL_ADDR_WIDTH-1:0]   s_axil_araddr_i,
    input  logic                                   s_axil_arvalid_i,
    output logic                                   s_axil_arready_o,
    output logic                                   s_axil_rvalid_o,
    output logic [pspl_pkg::AXIL_DATA_WIDTH-1:0]   s_axil_rdata_o,
    output logic [1:0]                             s_axil_rresp_o,
    input  logic                                   s_axil_rready_i,
    input  logic                                   spi_miso_i,
    output logic                                   spi_mosi_o,
    output logic                                   spi_clk_o,
    output logic [pspl_pkg::SPI_CS_WIDTH-1:0]      spi_cs_o,
    output logic [7:0]                             gpio_o
);
    import pspl_pkg::*;

    logic [REG_ADDR_WIDTH-1:0]    reg_addr;
    logic [AXIL_DATA_WIDTH-1:0]   reg_wdata;
    logic [AXIL_DATA_WIDTH/8-1:0] reg_wstrb;
    logic                         spi_wr_en, spi_rd_en;
    logic                         fifo_wr_en, fifo_rd_en;
    logic                         sys_wr_en, sys_rd_en;
    logic [AXIL_DATA_WIDTH-1:0]   spi_rdata, fifo_rdata, sys_rdata;

    axil_decoder i_axil_decoder (
        .clk_i, .reset_i,
        .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o,
        .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
        .s_axil_bvalid_o, .s_axil_bresp_o, .s_axil_bready_i,
        .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o,
        .s_axil_rvalid_o, .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rready_i,
        .reg_addr_o  (reg_addr),
        .reg_wdata_o (reg_wdata),
        .reg_wstrb_o (reg_wstrb),
        .spi_wr_en_o (spi_wr_en),
        .spi_rd_en_o (spi_rd_en),
        .spi_rdata_i (spi_rdata),
        .fifo_wr_en_o(fifo_wr_en),
        .fifo_rd_en_o(fifo_rd_en),
        .fifo_rdata_i(fifo_rdata),
        .sys_wr_en_o (sys_wr_en),
        .sys_rd_en_o (sys_rd_en),
        .sys_rdata_i (sys_rdata)
    );

    spi_master_regs i_spi_master_regs (
        .clk_i, .reset_i,
        .wr_en_i   (spi_wr_en),
        .rd_en_i   (spi_rd_en),
        .reg_addr_i(reg_addr),
        .wdata_i   (reg_wdata),
        .rdata_o   (spi_rdata),
        .spi_miso_i, .spi_mosi_o, .spi_clk_o, .spi_cs_o
    );

    reg_fifo i_reg_fifo (
        .clk_i, .reset_i,
        .wr_en_i   (fifo_wr_en),
        .rd_en_i   (fifo_rd_en),
        .reg_addr_i(reg_addr),
        .wdata_i   (reg_wdata),
        .rdata_o   (fifo_rdata)
    );

    sys_ctrl_regs i_sys_ctrl_regs (
        .clk_i, .reset_i,
        .wr_en_i   (sys_wr_en),
        .rd_en_i   (sys_rd_en),
        .reg_addr_i(reg_addr),
        .wdata_i   (reg_wdata),
        .wstrb_i   (reg_wstrb),
        .rdata_o   (sys_rdata),
        .gpio_o
    );

endmodule

/* design/sys_ctrl_regs.sv */
// Fixed ID, byte-writable scratch and an 8-bit GPIO output; unused indices read zero
module sys_ctrl_regs (
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  logic                                   wr_en_i,
    input  logic                                   rd_en_i,
    input  logic [pspl_pkg::REG_ADDR_WIDTH-1:0]    reg_addr_i,
    input  logic [pspl_pkg::AXIL_DATA_WIDTH-1:0]   wdata_i,
    input  logic [pspl_pkg::AXIL_DATA_WIDTH/8-1:0] wstrb_i,
    output logic [pspl_pkg::AXIL_DATA_WIDTH-1:0]   rdata_o,
    output logic [7:0]                             gpio_o
);
    import pspl_pkg::*;

    logic [AXIL_DATA_WIDTH-1:0] scratch;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            scratch <= '0;
            gpio_o  <= '0;
        end else if (wr_en_i) begin
            if (reg_addr_i == SYS_REG_SCRATCH) begin
                for (int i = 0; i < AXIL_DATA_WIDTH / 8; i++) begin
                    if (wstrb_i[i]) scratch[8*i+:8] <= wdata_i[8*i+:8];
                end
            end
            if (reg_addr_i == SYS_REG_GPIO) gpio_o <= wdata_i[7:0];
        end
    end

    always_comb begin
        rdata_o = '0;
        if (rd_en_i) begin
            case (reg_addr_i)
                SYS_REG_ID:      rdata_o      = PL_ID;
                SYS_REG_SCRATCH: rdata_o      = scratch;
                SYS_REG_GPIO:    rdata_o[7:0] = gpio_o;
                default:         rdata_o      = '0;
            endcase
        end
    end

endmodule

/* design/reg_fifo.sv */
// Register-accessed FIFO; one push or pop per bus access, wstrb is not honoured
module reg_fifo (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 wr_en_i,
    input  logic                                 rd_en_i,
    input  logic [pspl_pkg::REG_ADDR_WIDTH-1:0]  reg_addr_i,
    input  logic [pspl_pkg::AXIL_DATA_WIDTH-1:0] wdata_i,
    output logic [pspl_pkg::AXIL_DATA_WIDTH-1:0] rdata_o
);
    import pspl_pkg::*;

    logic [AXIL_DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [FIFO_CNT_WIDTH-2:0]  wr_ptr;
    logic [FIFO_CNT_WIDTH-2:0]  rd_ptr;
    logic [FIFO_CNT_WIDTH-1:0]  count;
    logic                       overflow;
    logic                       underflow;
    logic                       empty;
    logic                       full;
    logic                       push;
    logic                       pop;

    assign empty = (count == '0);
    assign full  = (count == FIFO_CNT_WIDTH'(FIFO_DEPTH));
    assign push  = wr_en_i && (reg_addr_i == FIFO_REG_DATA);
    assign pop   = rd_en_i && (reg_addr_i == FIFO_REG_DATA);

    always_ff @(posedge clk_i) begin
        if (push && !full) mem[wr_ptr] <= wdata_i;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (push) begin
                if (full) begin
                    overflow <= 1'b1;   // Word dropped
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    count  <= count + 1'b1;
                end
            end else if (pop) begin
                if (empty) begin
                    underflow <= 1'b1;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                    count  <= count - 1'b1;
                end
            end
            if (wr_en_i && reg_addr_i == FIFO_REG_CLEAR && wdata_i[0]) begin
                overflow  <= 1'b0;
                underflow <= 1'b0;
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_addr_i)
            FIFO_REG_DATA: rdata_o = (rd_en_i && !empty) ? mem[rd_ptr] : '0;
            FIFO_REG_STATUS: begin
                rdata_o[FIFO_CNT_WIDTH-1:0] = count;
                rdata_o[11:8] = {underflow, overflow, full, empty};
            end
            default: rdata_o = '0;
        endcase
        if (!rd_en_i) rdata_o = '0;
    end

endmodule

/* design/spi_master_regs.sv */
// Mode 0 only, 8-bit MSB-first frames; DATA writes while busy are dropped
module spi_master_regs (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 wr_en_i,
    input  logic                                 rd_en_i,
    input  logic [pspl_pkg::REG_ADDR_WIDTH-1:0]  reg_addr_i,
    input  logic [pspl_pkg::AXIL_DATA_WIDTH-1:0] wdata_i,
    output logic [pspl_pkg::AXIL_DATA_WIDTH-1:0] rdata_o,
    input  logic                                 spi_miso_i,
    output logic                                 spi_mosi_o,
    output logic                                 spi_clk_o,
    output logic [pspl_pkg::SPI_CS_WIDTH-1:0]    spi_cs_o
);
    import pspl_pkg::*;

    spi_state_e state;
    logic [7:0] clkdiv;
    logic [7:0] div_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] tx_shift;
    logic [7:0] rx_shift;
    logic [7:0] rx_data;
    logic       busy;
    logic       div_tick;
    logic       start;

    assign busy     = (state != SPI_IDLE);
    assign div_tick = (div_cnt == clkdiv - 8'd1);
    assign start    = wr_en_i && (reg_addr_i == SPI_REG_DATA) && !busy;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            clkdiv <= SPI_CLKDIV_RESET;
        end else if (wr_en_i && reg_addr_i == SPI_REG_CLKDIV) begin
            clkdiv <= (wdata_i[7:0] == 8'd0) ? 8'd1 : wdata_i[7:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state      <= SPI_IDLE;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            rx_data    <= '0;
            spi_cs_o   <= '1;
            spi_clk_o  <= 1'b0;
            spi_mosi_o <= 1'b0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    if (start) begin
                        tx_shift   <= wdata_i[7:0];
                        spi_mosi_o <= wdata_i[7];  // First bit ahead of first rising edge
                        spi_cs_o   <= '0;
                        div_cnt    <= '0;
                        bit_cnt    <= '0;
                        state      <= SPI_SHIFT;
                    end
                end
                SPI_SHIFT: begin
                    if (div_tick) begin
                        div_cnt   <= '0;
                        spi_clk_o <= !spi_clk_o;
                        if (!spi_clk_o) begin
                            rx_shift <= {rx_shift[6:0], spi_miso_i};  // Rising edge
                        end else if (bit_cnt == 3'd7) begin
                            rx_data <= rx_shift;
                            state   <= SPI_DONE;
                        end else begin
                            tx_shift   <= {tx_shift[6:0], 1'b0};
                            spi_mosi_o <= tx_shift[6];
                            bit_cnt    <= bit_cnt + 3'd1;
                        end
                    end else begin
                        div_cnt <= div_cnt + 8'd1;
                    end
                end
                SPI_DONE: begin
                    // Hold CS low for one more half period
                    if (div_tick) begin
                        div_cnt  <= '0;
                        spi_cs_o <= '1;
                        state    <= SPI_IDLE;
                    end else begin
                        div_cnt <= div_cnt + 8'd1;
                    end
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    always_comb begin
        rdata_o = '0;
        if (rd_en_i) begin
            case (reg_addr_i)
                SPI_REG_DATA:   rdata_o[7:0] = rx_data;
                SPI_REG_STATUS: rdata_o[0]   = busy;
                SPI_REG_CLKDIV: rdata_o[7:0] = clkdiv;
                default:        rdata_o      = '0;
            endcase
        end
    end

endmodule

/* design/axil_decoder.sv */
// One transaction at a time; write and data must arrive together; prot is not supported
module axil_decoder (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic [pspl_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_awaddr_i,
    input  logic                                 s_axil_awvalid_i,
    output logic                                 s_axil_awready_o,
    input  logic [pspl_pkg::AXIL_DATA_WIDTH-1:0] s_axil_wdata_i,
    input  logic [pspl_pkg::AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb_i,
    input  logic                                 s_axil_wvalid_i,
    output logic                                 s_axil_wready_o,
    output logic                                 s_axil_bvalid_o,
    output logic [1:0]                           s_axil_bresp_o,
    input  logic                                 s_axil_bready_i,
    input  logic [pspl_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_araddr_i,
    input  logic                                 s_axil_arvalid_i,
    output logic                                 s_axil_arready_o,
    output logic                                 s_axil_rvalid_o,
    output logic [pspl_pkg::AXIL_DATA_WIDTH-1:0] s_axil_rdata_o,
    output logic [1:0]                           s_axil_rresp_o,
    input  logic                                 s_axil_rready_i,
    output logic [pspl_pkg::REG_ADDR_WIDTH-1:0]  reg_addr_o,
    output logic [pspl_pkg::AXIL_DATA_WIDTH-1:0] reg_wdata_o,
    output logic [pspl_pkg::AXIL_DATA_WIDTH/8-1:0] reg_wstrb_o,
    output logic                                 spi_wr_en_o,
    output logic                                 spi_rd_en_o,
    input  logic [pspl_pkg::AXIL_DATA_WIDTH-1:0] spi_rdata_i,
    output logic                                 fifo_wr_en_o,
    output logic                                 fifo_rd_en_o,
    input  logic [pspl_pkg::AXIL_DATA_WIDTH-1:0] fifo_rdata_i,
    output logic                                 sys_wr_en_o,
    output logic                                 sys_rd_en_o,
    input  logic [pspl_pkg::AXIL_DATA_WIDTH-1:0] sys_rdata_i
);
    import pspl_pkg::*;

    dec_state_e                   state;
    slave_sel_e                   sel_q;
    logic [AXIL_ADDR_WIDTH-1:0]   addr_q;
    logic [AXIL_DATA_WIDTH-1:0]   wdata_q;
    logic [AXIL_DATA_WIDTH/8-1:0] wstrb_q;
    logic [AXIL_DATA_WIDTH-1:0]   rdata_q;
    logic [AXIL_DATA_WIDTH-1:0]   sel_rdata;
    logic                         bvalid_q;
    logic                         rvalid_q;
    logic                         wr_take;
    logic                         rd_take;

    function automatic slave_sel_e decode_window(input logic [AXIL_ADDR_WIDTH-1:0] addr);
        logic [AXIL_ADDR_WIDTH-1:0] win;
        win = addr & WINDOW_MASK;
        if (win == SPI_BASE)       return SEL_SPI;
        else if (win == FIFO_BASE) return SEL_FIFO;
        else if (win == SYS_BASE)  return SEL_SYS;
        else                       return SEL_NONE;
    endfunction

    assign wr_take = (state == DEC_IDLE) && s_axil_awvalid_i && s_axil_wvalid_i;
    assign rd_take = (state == DEC_IDLE) && s_axil_arvalid_i && !wr_take;   // Write wins

    assign s_axil_awready_o = wr_take;
    assign s_axil_wready_o  = wr_take;
    assign s_axil_arready_o = rd_take;

    // Address, data and window latched once per transaction
    always_ff @(posedge clk_i) begin
        if (wr_take) begin
            addr_q  <= s_axil_awaddr_i;
            wdata_q <= s_axil_wdata_i;
            wstrb_q <= s_axil_wstrb_i;
            sel_q   <= decode_window(s_axil_awaddr_i);
        end else if (rd_take) begin
            addr_q <= s_axil_araddr_i;
            sel_q  <= decode_window(s_axil_araddr_i);
        end
        if (state == DEC_RD_ACCESS) rdata_q <= sel_rdata;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state    <= DEC_IDLE;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (wr_take)      state <= DEC_WR_ACCESS;
                    else if (rd_take) state <= DEC_RD_ACCESS;
                end
                DEC_WR_ACCESS: state <= DEC_WR_RESP;
                DEC_WR_RESP: begin
                    if (!bvalid_q) begin
                        bvalid_q <= 1'b1;
                    end else if (s_axil_bready_i) begin
                        bvalid_q <= 1'b0;
                        state    <= DEC_IDLE;
                    end
                end
                DEC_RD_ACCESS: state <= DEC_RD_RESP;
                DEC_RD_RESP: begin
                    if (!rvalid_q) begin
                        rvalid_q <= 1'b1;
                    end else if (s_axil_rready_i) begin
                        rvalid_q <= 1'b0;
                        state    <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    always_comb begin
        case (sel_q)
            SEL_SPI:  sel_rdata = spi_rdata_i;
            SEL_FIFO: sel_rdata = fifo_rdata_i;
            SEL_SYS:  sel_rdata = sys_rdata_i;
            default:  sel_rdata = '0;   // Unmapped reads return zero
        endcase
    end

    assign reg_addr_o  = addr_q[REG_ADDR_WIDTH+1:2];
    assign reg_wdata_o = wdata_q;
    assign reg_wstrb_o = wstrb_q;

    assign spi_wr_en_o  = (state == DEC_WR_ACCESS) && (sel_q == SEL_SPI);
    assign fifo_wr_en_o = (state == DEC_WR_ACCESS) && (sel_q == SEL_FIFO);
    assign sys_wr_en_o  = (state == DEC_WR_ACCESS) && (sel_q == SEL_SYS);
    assign spi_rd_en_o  = (state == DEC_RD_ACCESS) && (sel_q == SEL_SPI);
    assign fifo_rd_en_o = (state == DEC_RD_ACCESS) && (sel_q == SEL_FIFO);
    assign sys_rd_en_o  = (state == DEC_RD_ACCESS) && (sel_q == SEL_SYS);

    assign s_axil_bvalid_o = bvalid_q;
    assign s_axil_rvalid_o = rvalid_q;
    assign s_axil_rdata_o  = rdata_q;
    assign s_axil_bresp_o  = (sel_q == SEL_NONE) ? RESP_DECERR : RESP_OKAY;
    assign s_axil_rresp_o  = (sel_q == SEL_NONE) ? RESP_DECERR : RESP_OKAY;

endmodule

/* design/pspl_pkg.sv */
// Fixed 64 KiB windows with four registers each; only one bus master on clk_i
package pspl_pkg;

    localparam int AXIL_ADDR_WIDTH = 32;
    localparam int AXIL_DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH  = 2;     // Address bits 3:2

    localparam logic [AXIL_ADDR_WIDTH-1:0] SPI_BASE    = 32'h43c0_0000;
    localparam logic [AXIL_ADDR_WIDTH-1:0] FIFO_BASE   = 32'h43c1_0000;
    localparam logic [AXIL_ADDR_WIDTH-1:0] SYS_BASE    = 32'h43c2_0000;
    localparam logic [AXIL_ADDR_WIDTH-1:0] WINDOW_MASK = 32'hffff_0000;

    localparam int                        SPI_CS_WIDTH     = 1;
    localparam logic [REG_ADDR_WIDTH-1:0] SPI_REG_DATA     = 2'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] SPI_REG_STATUS   = 2'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] SPI_REG_CLKDIV   = 2'd2;
    localparam logic [7:0]                SPI_CLKDIV_RESET = 8'd4;

    localparam int                        FIFO_DEPTH      = 16;
    localparam int                        FIFO_CNT_WIDTH  = 5;
    localparam logic [REG_ADDR_WIDTH-1:0] FIFO_REG_DATA   = 2'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] FIFO_REG_STATUS = 2'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] FIFO_REG_CLEAR  = 2'd2;

    localparam logic [REG_ADDR_WIDTH-1:0]  SYS_REG_ID      = 2'd0;
    localparam logic [REG_ADDR_WIDTH-1:0]  SYS_REG_SCRATCH = 2'd1;
    localparam logic [REG_ADDR_WIDTH-1:0]  SYS_REG_GPIO    = 2'd2;
    localparam logic [AXIL_DATA_WIDTH-1:0] PL_ID           = 32'h5053_504c;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } axil_resp_e;

    typedef enum logic [1:0] {SEL_SPI, SEL_FIFO, SEL_SYS, SEL_NONE} slave_sel_e;

    typedef enum logic [2:0] {
        DEC_IDLE,
        DEC_WR_ACCESS,
        DEC_WR_RESP,
        DEC_RD_ACCESS,
        DEC_RD_RESP
    } dec_state_e;

    typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_DONE} spi_state_e;

endpackage
